//--- all.f
+incdir+verification
common/bpredPkg.sv
bpred/dirPredictor.sv
bpred/btb.sv
bpred/rasPredictor.sv
bpred/bpred.sv
verification/bpredTb.sv

//--- bpred/bpred.sv
// Branch prediction unit forming the next fetch address and checking it in execute
`default_nettype none

module bpred (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 StallF,
  input  logic                 StallD,
  input  logic                 StallE,
  input  logic                 StallM,
  input  logic                 FlushD,
  input  logic                 FlushE,
  input  logic                 FlushM,
  input  bpredPkg::pcT         PCNextF,
  input  bpredPkg::pcT         PCF,
  input  bpredPkg::pcT         PCD,
  input  bpredPkg::pcT         PCE,
  input  bpredPkg::pcT         IEUAdrE,
  input  bpredPkg::pcT         PCLinkE,
  input  logic                 InstrValidD,
  input  logic                 InstrValidE,
  input  logic                 PCSrcE,
  input  bpredPkg::instrClassT InstrClassE,
  output bpredPkg::pcT         PC1NextF,
  output logic                 BPWrongE,
  output logic                 BPWrongM,
  output logic                 BPDirPredWrongM,
  output logic                 BTBPredPCWrongM,
  output logic                 RASPredPCWrongM
);
  import bpredPkg::*;

  // Table outputs
  dirStateT   BPDirPredF;
  logic       BPDirPredWrongE;
  pcT         BTAF, BTAE, RASPCF;
  instrClassT BTBClassF;
  // Fetch side
  logic       BPPCSrcF;
  pcT         BPPCF, PC0NextF, PCPlus4F;
  // Execute side
  instrClassT ClassE;
  logic       TakenE, BTBUpdateE;
  logic       BTBPredPCWrongE, RASPredPCWrongE;
  pcT         PCCorrectE, RASPCD, RASPCE;

  //////////////////////////////
  // Prediction tables
  //////////////////////////////

  // Class of a valid E instruction, zero for a bubble
  assign ClassE = InstrValidE ? InstrClassE : '0;
  assign TakenE = ClassE[classJump] | (ClassE[classBranch] & PCSrcE);
  // BTB learns only taken control flow
  assign BTBUpdateE = TakenE & ~StallE;

  dirPredictor dirPred (
    .clk, .arstN, .StallF, .StallD, .StallE, .FlushD, .FlushE,
    .PCNextF, .PCE,
    .BranchE(ClassE[classBranch]),
    .PCSrcE,
    .BPDirPredF, .BPDirPredWrongE
  );

  btb targetPred (
    .clk, .arstN, .StallF, .StallD, .StallE, .FlushD, .FlushE,
    .PCNextF, .PCE, .IEUAdrE, .InstrClassE,
    .UpdateE(BTBUpdateE),
    .BTAF, .BTAE, .BTBClassF
  );

  // RAS qualifies with InstrValidE and StallE itself
  rasPredictor rasPred (
    .clk, .arstN, .StallE, .InstrValidE,
    .CallE(InstrClassE[classCall]),
    .ReturnE(InstrClassE[classReturn]),
    .PCLinkE, .RASPCF
  );

  //////////////////////////////
  // Fetch address mux
  //////////////////////////////

  assign PCPlus4F = PCF + pcT'(4);
  // BTB class is zero on a miss, so any set bit implies a hit
  assign BPPCSrcF = BTBClassF[classJump] |
                    (BTBClassF[classBranch] & (BPDirPredF inside {weakTaken, strongTaken}));
  // Returns take the stack top instead of the stored target
  assign BPPCF    = BTBClassF[classReturn] ? RASPCF : BTAF;
  assign PC0NextF = BPPCSrcF ? BPPCF : PCPlus4F;
  // Correction from E overrides any prediction
  assign PC1NextF = BPWrongE ? PCCorrectE : PC0NextF;

  //////////////////////////////
  // Execute stage check
  //////////////////////////////

  assign PCCorrectE = PCSrcE ? IEUAdrE : PCLinkE;
  // PCD is the address fetch actually followed
  assign BPWrongE   = (PCCorrectE != PCD) & InstrValidE & InstrValidD;

  // Target causes, measured on the carried predictions and not on PCD
  assign BTBPredPCWrongE = (BTAE != IEUAdrE) & PCSrcE &
                           (ClassE[classBranch] | (ClassE[classJump] & ~ClassE[classReturn]));
  assign RASPredPCWrongE = (RASPCE != IEUAdrE) & ClassE[classReturn] & PCSrcE;

  // Stack top travels with the instruction for the accuracy check
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      RASPCD <= '0;
      RASPCE <= '0;
    end else begin
      if (FlushD) RASPCD <= '0;
      else if (!StallD) RASPCD <= RASPCF;
      if (FlushE) RASPCE <= '0;
      else if (!StallE) RASPCE <= RASPCD;
    end
  end

  // M stage status flags, one cycle behind E
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      BPWrongM        <= 1'b0;
      BPDirPredWrongM <= 1'b0;
      BTBPredPCWrongM <= 1'b0;
      RASPredPCWrongM <= 1'b0;
    end else if (FlushM) begin
      BPWrongM        <= 1'b0;
      BPDirPredWrongM <= 1'b0;
      BTBPredPCWrongM <= 1'b0;
      RASPredPCWrongM <= 1'b0;
    end else if (!StallM) begin
      BPWrongM        <= BPWrongE;
      BPDirPredWrongM <= BPDirPredWrongE;
      BTBPredPCWrongM <= BTBPredPCWrongE;
      RASPredPCWrongM <= RASPredPCWrongE;
    end
  end

  // Decode must hand over a legal class, jump only rides with call or return
  assert property (@(posedge clk) disable iff (!arstN)
    InstrValidE |-> $onehot0({InstrClassE[classCall], InstrClassE[classReturn],
                              InstrClassE[classJump] & ~InstrClassE[classCall] &
                              ~InstrClassE[classReturn],
                              InstrClassE[classBranch]}))
    else $error("illegal instruction class in E");

endmodule

`default_nettype wire

//--- bpred/btb.sv
// Direct-mapped tagged branch target buffer holding target and instruction class
`default_nettype none

module btb (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 StallF,
  input  logic                 StallD,
  input  logic                 StallE,
  input  logic                 FlushD,
  input  logic                 FlushE,
  input  bpredPkg::pcT         PCNextF,
  input  bpredPkg::pcT         PCE,
  input  bpredPkg::pcT         IEUAdrE,
  input  bpredPkg::instrClassT InstrClassE,
  input  logic                 UpdateE,
  output bpredPkg::pcT         BTAF,
  output bpredPkg::pcT         BTAE,
  output bpredPkg::instrClassT BTBClassF
);
  import bpredPkg::*;

  // Entry storage, only the valid bits are control state
  logic [btbEntries-1:0] validBits;
  btbTagT                tagMem    [btbEntries];
  pcT                    targetMem [btbEntries];
  instrClassT            classMem  [btbEntries];

  btbIdxT     rdIdx, wrIdx;
  logic       rdHit;
  instrClassT rdClass;
  pcT         rdTarget;
  pcT         BTAD;

  //////////////////////////////
  // Lookup with PCNextF
  //////////////////////////////

  assign rdIdx = btbIndex(PCNextF);
  assign wrIdx = btbIndex(PCE);

  assign rdHit    = validBits[rdIdx] & (tagMem[rdIdx] == btbTagOf(PCNextF));
  // Miss reads as no control flow and a zero target
  assign rdClass  = rdHit ? classMem[rdIdx] : '0;
  assign rdTarget = rdHit ? targetMem[rdIdx] : '0;

  //////////////////////////////
  // Update from E
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validBits <= '0;
    end else if (UpdateE) begin
      validBits[wrIdx] <= 1'b1;
    end
  end

  // Overwrites whatever lived in the slot, no replacement choice
  always_ff @(posedge clk) begin
    if (UpdateE) begin
      tagMem[wrIdx]    <= btbTagOf(PCE);
      targetMem[wrIdx] <= IEUAdrE;
      classMem[wrIdx]  <= InstrClassE;
    end
  end

  //////////////////////////////
  // F result and target pipe
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      BTAF      <= '0;
      BTBClassF <= '0;
    end else if (!StallF) begin
      BTAF      <= rdTarget;
      BTBClassF <= rdClass;
    end
  end

  // Predicted target follows the instruction to E
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      BTAD <= '0;
      BTAE <= '0;
    end else begin
      if (FlushD) BTAD <= '0;
      else if (!StallD) BTAD <= BTAF;
      if (FlushE) BTAE <= '0;
      else if (!StallE) BTAE <= BTAD;
    end
  end

endmodule

`default_nettype wire

//--- bpred/dirPredictor.sv
// Two-bit saturating counter table predicting branch direction in fetch
`default_nettype none

module dirPredictor (
  input  logic               clk,
  input  logic               arstN,
  input  logic               StallF,
  input  logic               StallD,
  input  logic               StallE,
  input  logic               FlushD,
  input  logic               FlushE,
  input  bpredPkg::pcT       PCNextF,
  input  bpredPkg::pcT       PCE,
  input  logic               BranchE,
  input  logic               PCSrcE,
  output bpredPkg::dirStateT BPDirPredF,
  output logic               BPDirPredWrongE
);
  import bpredPkg::*;

  dirStateT dirTable [bhtEntries];
  dirStateT BPDirPredD, BPDirPredE;
  dirStateT oldState, newState;
  bhtIdxT   rdIdx, updIdx;
  logic     updateE;

  // Saturating step toward the resolved outcome
  function automatic dirStateT stepToward(dirStateT cur, logic taken);
    dirStateT nxt;
    case (cur)
      strongNotTaken: nxt = taken ? weakNotTaken : strongNotTaken;
      weakNotTaken:   nxt = taken ? weakTaken    : strongNotTaken;
      weakTaken:      nxt = taken ? strongTaken  : weakNotTaken;
      strongTaken:    nxt = taken ? strongTaken  : weakTaken;
      default:        nxt = dirResetState;
    endcase
    return nxt;
  endfunction

  function automatic int stateDistance(dirStateT a, dirStateT b);
    int diff;
    diff = int'(a) - int'(b);
    return (diff < 0) ? -diff : diff;
  endfunction

  assign rdIdx    = bhtIndex(PCNextF);
  assign updIdx   = bhtIndex(PCE);
  // BranchE is already qualified by InstrValidE
  assign updateE  = BranchE & ~StallE;
  assign oldState = dirTable[updIdx];
  assign newState = stepToward(oldState, PCSrcE);

  // Counter table, all weakly not taken out of reset
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < bhtEntries; i++) begin
        dirTable[i] <= dirResetState;
      end
    end else if (updateE) begin
      dirTable[updIdx] <= newState;
    end
  end

  // Prediction for F, then carried down to E
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      BPDirPredF <= dirResetState;
      BPDirPredD <= strongNotTaken;
      BPDirPredE <= strongNotTaken;
    end else begin
      if (!StallF) BPDirPredF <= dirTable[rdIdx];
      if (FlushD) BPDirPredD <= strongNotTaken;
      else if (!StallD) BPDirPredD <= BPDirPredF;
      if (FlushE) BPDirPredE <= strongNotTaken;
      else if (!StallE) BPDirPredE <= BPDirPredD;
    end
  end

  // Direction miss only counts for branches
  assign BPDirPredWrongE = BranchE & ((BPDirPredE inside {weakTaken, strongTaken}) != PCSrcE);

  // A single update never skips a counter state
  assert property (@(posedge clk) disable iff (!arstN)
    updateE |=> stateDistance(dirTable[$past(updIdx)], $past(oldState)) <= 1)
    else $error("direction counter moved more than one state");

endmodule

`default_nettype wire

//--- bpred/rasPredictor.sv
// Four-entry return address stack, pushed by calls and popped by returns in E
`default_nettype none

module rasPredictor (
  input  logic         clk,
  input  logic         arstN,
  input  logic         StallE,
  input  logic         InstrValidE,
  input  logic         CallE,
  input  logic         ReturnE,
  input  bpredPkg::pcT PCLinkE,
  output bpredPkg::pcT RASPCF
);
  import bpredPkg::*;

  pcT       stackMem [rasDepth];
  rasPtrT   topPtr, pushPtr;
  rasCountT count;
  logic     retireE, pushE, popE;

  // Only resolved instructions touch the stack
  assign retireE = InstrValidE & ~StallE;
  assign pushE   = retireE & CallE;
  // Pop of an empty stack is dropped
  assign popE    = retireE & ReturnE & (count != '0);
  // Pointer wraps, so a push when full lands on the oldest entry
  assign pushPtr = topPtr + 1'b1;

  //////////////////////////////
  // Pointer and occupancy
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      topPtr <= '0;
      count  <= '0;
    end else if (pushE) begin
      topPtr <= pushPtr;
      // Saturates at depth, oldest entry is lost
      if (count != rasCountT'(rasDepth)) count <= count + 1'b1;
    end else if (popE) begin
      topPtr <= topPtr - 1'b1;
      count  <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pushE) begin
      stackMem[pushPtr] <= PCLinkE;
    end
  end

  // Empty stack reads zero
  assign RASPCF = (count == '0) ? '0 : stackMem[topPtr];

  // Decode never marks one instruction as both call and return
  assert property (@(posedge clk) disable iff (!arstN)
    InstrValidE |-> !(CallE && ReturnE))
    else $error("call and return together in E");

endmodule

`default_nettype wire

//--- common/bpredPkg.sv
// Branch predictor package with table sizes, vector types and class encodings
`default_nettype none

package bpredPkg;

  //////////////////////////////
  // Address width
  //////////////////////////////

  localparam int xLen = 32;
  // Instruction addresses and targets
  typedef logic [xLen-1:0] pcT;

  //////////////////////////////
  // Table geometry
  //////////////////////////////

  // Direction table, 16 counters indexed by PC[5:2]
  localparam int bhtIdxBits = 4;
  localparam int bhtEntries = 2 ** bhtIdxBits;
  typedef logic [bhtIdxBits-1:0] bhtIdxT;

  // Direct mapped BTB, index PC[5:2] and tag PC[31:6]
  localparam int btbIdxBits = 4;
  localparam int btbEntries = 2 ** btbIdxBits;
  localparam int btbTagBits = 26;
  typedef logic [btbIdxBits-1:0] btbIdxT;
  typedef logic [btbTagBits-1:0] btbTagT;

  // Return address stack
  localparam int rasDepth = 4;
  typedef logic [$clog2(rasDepth)-1:0]   rasPtrT;
  // Occupancy runs from 0 up to rasDepth
  typedef logic [$clog2(rasDepth+1)-1:0] rasCountT;

  //////////////////////////////
  // Instruction class
  //////////////////////////////

  // One hot, zero means no control flow
  // Calls and returns carry the jump bit as well
  typedef logic [3:0] instrClassT;
  localparam int classCall   = 3;
  localparam int classReturn = 2;
  localparam int classJump   = 1;
  localparam int classBranch = 0;

  // Two-bit counter states, upper half predicts taken
  typedef enum logic [1:0] {
    strongNotTaken = 2'b00,
    weakNotTaken   = 2'b01,
    weakTaken      = 2'b10,
    strongTaken    = 2'b11
  } dirStateT;

  localparam dirStateT dirResetState = weakNotTaken;

  //////////////////////////////
  // Index and tag extraction
  //////////////////////////////

  function automatic bhtIdxT bhtIndex(pcT pc);
    return pc[bhtIdxBits+1:2];
  endfunction

  function automatic btbIdxT btbIndex(pcT pc);
    return pc[btbIdxBits+1:2];
  endfunction

  function automatic btbTagT btbTagOf(pcT pc);
    return pc[xLen-1:btbIdxBits+2];
  endfunction

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build the branch predictor testbench with Verilator, run it and check the log
set -u

cd "$(dirname "$0")" || exit 1

buildLog=build.log
simLog=sim.log

if ! verilator --binary --timing --assert --top-module bpredTb -f all.f > "$buildLog" 2>&1; then
  cat "$buildLog"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VbpredTb > "$simLog" 2>&1
simStatus=$?
cat "$simLog"

if grep -q "Test failed" "$simLog"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ "$simStatus" -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- verification/bpredModel.svh
// Reference model of the branch predictor with shadow tables and expected results
`ifndef BPRED_MODEL_SVH
`define BPRED_MODEL_SVH

//////////////////////////////
// Shadow state
//////////////////////////////

// Counters as plain integers, 0 strongly not taken up to 3 strongly taken
int          shDir    [16];
logic        shValid  [16];
logic [25:0] shTag    [16];
pcT          shTarget [16];
instrClassT  shClass  [16];
// Newest return address at the back
pcT          shRas [$];
// Predictions carried with the instruction from F to E
int          mdDirF, mdDirD, mdDirE;
instrClassT  mdClsF;
pcT          mdBtaF, mdBtaD, mdBtaE, mdRasD, mdRasE;
logic        mdWrongM, mdDirWrongM, mdBtbWrongM, mdRasWrongM;
logic [15:0] lfsrState;

// Fibonacci LFSR with taps 16, 14, 13, 11, one step per bit
function automatic logic lfsrNext();
  logic fb;
  fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
  lfsrState = {lfsrState[14:0], fb};
  return fb;
endfunction

function automatic int randBits(int n);
  int v;
  v = 0;
  for (int i = 0; i < n; i++)
    v = (v << 1) | int'(lfsrNext());
  return v;
endfunction

function automatic pcT rasTop();
  return (shRas.size() == 0) ? '0 : shRas[$];
endfunction

function automatic pcT correctedPc();
  return PCSrcE ? IEUAdrE : PCLinkE;
endfunction

// Causes packed as {wrong, direction, BTB target, RAS target}
function automatic logic [3:0] expectedCausesE();
  instrClassT cls;
  logic       wrong, dirWrong, btbWrong, rasWrong;
  cls      = InstrValidE ? InstrClassE : '0;
  wrong    = InstrValidE && InstrValidD && (correctedPc() != PCD);
  dirWrong = cls[classBranch] && ((mdDirE >= 2) != PCSrcE);
  // Any taken control flow except a return checks the stored target
  btbWrong = PCSrcE && (cls != '0) && !cls[classReturn] && (mdBtaE != IEUAdrE);
  rasWrong = PCSrcE && cls[classReturn] && (mdRasE != IEUAdrE);
  return {wrong, dirWrong, btbWrong, rasWrong};
endfunction

function automatic pcT expectedNextPc();
  logic [3:0] causes;
  logic       predTaken;
  pcT         predPc;
  causes    = expectedCausesE();
  predTaken = mdClsF[classJump] || (mdClsF[classBranch] && mdDirF >= 2);
  predPc    = mdClsF[classReturn] ? rasTop() : mdBtaF;
  // Execute correction wins over the fetch guess
  if (causes[3])
    return correctedPc();
  return predTaken ? predPc : PCF + pcT'(4);
endfunction

task automatic resetModel();
  for (int i = 0; i < 16; i++) begin
    shDir[i]    = 1;
    shValid[i]  = 1'b0;
    shTag[i]    = '0;
    shTarget[i] = '0;
    shClass[i]  = '0;
  end
  shRas.delete();
  mdDirF = 1;
  mdDirD = 0;
  mdDirE = 0;
  mdClsF = '0;
  {mdBtaF, mdBtaD, mdBtaE, mdRasD, mdRasE} = '0;
  {mdWrongM, mdDirWrongM, mdBtbWrongM, mdRasWrongM} = '0;
endtask

// Mirrors one rising edge, using the inputs held during the cycle that ends
task automatic stepModel();
  logic [3:0] causes;
  logic       hit;
  pcT         top;
  instrClassT cls;
  int         rd;
  int         wr;
  causes = expectedCausesE();
  top    = rasTop();
  cls    = InstrValidE ? InstrClassE : '0;
  rd     = int'(PCNextF[5:2]);
  wr     = int'(PCE[5:2]);
  if (FlushM)
    {mdWrongM, mdDirWrongM, mdBtbWrongM, mdRasWrongM} = '0;
  else if (!StallM)
    {mdWrongM, mdDirWrongM, mdBtbWrongM, mdRasWrongM} = causes;
  // E copies first so each stage takes the older value
  if (FlushE) begin
    mdDirE = 0;
    mdBtaE = '0;
    mdRasE = '0;
  end else if (!StallE) begin
    mdDirE = mdDirD;
    mdBtaE = mdBtaD;
    mdRasE = mdRasD;
  end
  if (FlushD) begin
    mdDirD = 0;
    mdBtaD = '0;
    mdRasD = '0;
  end else if (!StallD) begin
    mdDirD = mdDirF;
    mdBtaD = mdBtaF;
    mdRasD = top;
  end
  // Lookup sees the tables as they were before this edge
  if (!StallF) begin
    hit    = shValid[rd] && (shTag[rd] == PCNextF[31:6]);
    mdDirF = shDir[rd];
    mdClsF = hit ? shClass[rd] : '0;
    mdBtaF = hit ? shTarget[rd] : '0;
  end
  if (InstrValidE && !StallE) begin
    if (cls[classBranch])
      shDir[wr] = PCSrcE ? ((shDir[wr] == 3) ? 3 : shDir[wr] + 1)
                         : ((shDir[wr] == 0) ? 0 : shDir[wr] - 1);
    if (cls[classJump] || (cls[classBranch] && PCSrcE)) begin
      shValid[wr]  = 1'b1;
      shTag[wr]    = PCE[31:6];
      shTarget[wr] = IEUAdrE;
      shClass[wr]  = InstrClassE;
    end
    // Full stack drops its oldest entry
    if (cls[classCall]) begin
      shRas.push_back(PCLinkE);
      if (shRas.size() > 4)
        void'(shRas.pop_front());
    end else if (cls[classReturn] && shRas.size() != 0) begin
      void'(shRas.pop_back());
    end
  end
endtask

`endif

//--- verification/bpredTb.sv
// Testbench for the branch prediction unit that drives a modeled F, D, E instruction stream
`default_nettype none

module bpredTb;
  import bpredPkg::*;

  localparam int resetCycles  = 10;
  localparam int scriptCycles = 400;
  localparam int randomCycles = 3000;
  localparam int watchLimit   = (resetCycles + scriptCycles + randomCycles) * 40 + 2000;
  localparam pcT scriptBase   = 32'h0000_1000;
  // Same indices as the script but another tag
  localparam pcT randomBase   = 32'h0000_2000;

  logic       clk, arstN;
  logic       StallF, StallD, StallE, StallM, FlushD, FlushE, FlushM;
  pcT         PCNextF, PCF, PCD, PCE, IEUAdrE, PCLinkE, PC1NextF;
  logic       InstrValidD, InstrValidE, PCSrcE;
  instrClassT InstrClassE;
  logic       BPWrongE, BPWrongM, BPDirPredWrongM, BTBPredPCWrongM, RASPredPCWrongM;

  // F and D contents while E lives directly on the DUT inputs
  logic       fValid, fTaken, dTaken;
  instrClassT fCls, dCls;
  pcT         fTgt, dTgt;
  // Program image indexed by PC[5:2]
  instrClassT progClass  [16];
  pcT         progTarget [16];
  logic       randomPhase, scriptTaken;
  int         missCount, rasHitCount;

  `include "bpredModel.svh"

  bpred dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic placeInstr(int idx, instrClassT cls, int offset);
    progClass[idx]  = cls;
    progTarget[idx] = scriptBase + pcT'(offset);
  endtask

  // Loop with five nested calls so the outermost return overflows the stack
  task automatic loadScript();
    for (int i = 0; i < 16; i++)
      placeInstr(i, '0, 4 * i + 4);
    placeInstr(1, 4'b1010, 'h10);
    placeInstr(2, 4'b0001, 'h00);
    placeInstr(3, 4'b0010, 'h00);
    placeInstr(4, 4'b1010, 'h18);
    placeInstr(5, 4'b0110, 'h08);
    placeInstr(6, 4'b1010, 'h20);
    placeInstr(7, 4'b0110, 'h14);
    placeInstr(8, 4'b1010, 'h28);
    placeInstr(9, 4'b0110, 'h1C);
    placeInstr(10, 4'b1010, 'h30);
    placeInstr(11, 4'b0110, 'h24);
    placeInstr(13, 4'b0110, 'h2C);
  endtask

  task automatic loadRandom();
    int pick;
    for (int i = 0; i < 16; i++) begin
      pick = randBits(3);
      case (pick)
        2, 3:    progClass[i] = 4'b0001;
        4:       progClass[i] = 4'b0010;
        5:       progClass[i] = 4'b1010;
        6:       progClass[i] = 4'b0110;
        default: progClass[i] = '0;
      endcase
      progTarget[i] = randomBase + pcT'(randBits(4) * 4);
    end
  endtask

  // Branch outcome is fixed at fetch and jumps are always taken
  task automatic fetchInstr(pcT pc);
    int idx;
    idx    = int'(pc[5:2]);
    PCF    = pc;
    fValid = 1'b1;
    fCls   = progClass[idx];
    fTgt   = progTarget[idx];
    fTaken = fCls[classJump] || (fCls[classBranch] && (randomPhase ? lfsrNext() : scriptTaken));
  endtask

  // Flush wins over stall as in the core
  task automatic advancePipe();
    if (FlushE) begin
      InstrValidE = 1'b0;
      InstrClassE = '0;
      PCSrcE      = 1'b0;
    end else if (!StallE) begin
      InstrValidE = InstrValidD;
      PCE         = PCD;
      InstrClassE = dCls;
      PCSrcE      = dTaken;
      IEUAdrE     = dTgt;
    end
    PCLinkE = PCE + pcT'(4);
    if (FlushD) begin
      InstrValidD = 1'b0;
      dCls        = '0;
      dTaken      = 1'b0;
    end else if (!StallD) begin
      InstrValidD = fValid;
      PCD         = PCF;
      dCls        = fCls;
      dTaken      = fTaken;
      dTgt        = fTgt;
    end
    if (!StallF)
      fetchInstr(PCNextF);
  endtask

  // Whole front end stalls together and a miss flushes D and E
  task automatic chooseControls();
    logic       stall;
    logic [3:0] causes;
    stall  = randomPhase && (randBits(2) == 3);
    causes = expectedCausesE();
    StallF = stall;
    StallD = stall;
    StallE = stall;
    StallM = stall;
    FlushD = !stall && causes[3];
    FlushE = !stall && (causes[3] || (randomPhase && randBits(4) == 0));
    FlushM = randomPhase && (randBits(3) == 0);
    PCNextF = expectedNextPc();
  endtask

  task automatic checkValue(string name, pcT got, pcT want);
    if (got !== want) begin
      $display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, want);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  //////////////////////////////
  // Compare on the falling edge
  //////////////////////////////

  always @(negedge clk) begin : compare
    logic [3:0] causes;
    causes = expectedCausesE();
    checkValue("PC1NextF", PC1NextF, expectedNextPc());
    checkValue("BPWrongE", pcT'(BPWrongE), pcT'(causes[3]));
    checkValue("BPWrongM", pcT'(BPWrongM), pcT'(mdWrongM));
    checkValue("BPDirPredWrongM", pcT'(BPDirPredWrongM), pcT'(mdDirWrongM));
    checkValue("BTBPredPCWrongM", pcT'(BTBPredPCWrongM), pcT'(mdBtbWrongM));
    checkValue("RASPredPCWrongM", pcT'(RASPredPCWrongM), pcT'(mdRasWrongM));
    if (causes[3])
      missCount++;
    // Return that retires with a correct stack target
    if (InstrValidE && InstrClassE[classReturn] && !StallE && !causes[0])
      rasHitCount++;
  end

  initial begin
    #(watchLimit);
    $display("Timeout: the stream did not finish within %0d time units", watchLimit);
    $display("Test failed");
    $fatal(1);
  end

  //////////////////////////////
  // Reset and stream
  //////////////////////////////

  initial begin
    lfsrState   = 16'd69;
    missCount   = 0;
    rasHitCount = 0;
    randomPhase = 1'b0;
    scriptTaken = 1'b1;
    arstN       = 1'b0;
    {StallF, StallD, StallE, StallM, FlushD, FlushE, FlushM} = '0;
    {InstrValidD, InstrValidE, PCSrcE, dTaken, fTaken, fValid} = '0;
    {InstrClassE, dCls, fCls} = '0;
    {PCD, PCE, IEUAdrE, dTgt, fTgt} = '0;
    PCLinkE = pcT'(4);
    // Bubble in F just below the entry point
    PCF     = scriptBase - pcT'(4);
    PCNextF = scriptBase;
    loadScript();
    resetModel();
    repeat (resetCycles) @(posedge clk);
    #2;
    arstN = 1'b1;
    for (int cyc = 0; cyc < scriptCycles + randomCycles; cyc++) begin
      @(posedge clk);
      #2;
      stepModel();
      // Loop branch is taken first and falls through later
      scriptTaken = (cyc < scriptCycles / 2);
      if (cyc == scriptCycles) begin
        randomPhase = 1'b1;
        loadRandom();
      end
      advancePipe();
      chooseControls();
    end
    // Last falling edge compare is complete by the next rising edge
    @(posedge clk);
    if (missCount > 0 && rasHitCount > 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("The stream never hit a misprediction or a correct return prediction");
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
